//--- compile.f
fpuPkg.sv
fpuMultiplier.sv
fpuNormalizer.sv
fpuMul16.sv
fpuCoprocessor.sv
fpuCoprocessor_props.sv
tbFpuCoprocessor.sv

//--- fpuCoprocessor.sv
/*
  Binary16 multiply coprocessor.
  Four-phase req/ack front end around the multiply unit. Holds the
  operands, the result and the zero, negative and status flags, which
  stay valid for as long as ack is high.
*/

`timescale 1ns/100ps
`default_nettype none

module fpuCoprocessor (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             req,
  input  logic [fpuPkg::fp16Width-1:0]     operandA,
  input  logic [fpuPkg::fp16Width-1:0]     operandB,
  output logic                             ack,
  output logic [fpuPkg::fp16Width-1:0]     result,
  output logic                             zero,
  output logic                             negative,
  output logic [fpuPkg::statusWidth-1:0]   status
);

  localparam int signPos = fpuPkg::fp16Width - 1;

  typedef enum logic [1:0] {
    hsWaitReq,
    hsIdle,
    hsBusy,
    hsAck
  } hsStateType;

  hsStateType hsState;

  logic [fpuPkg::fp16Width-1:0] opA;
  logic [fpuPkg::fp16Width-1:0] opB;
  logic [fpuPkg::fp16Width-1:0] mulResult;
  logic [fpuPkg::statusWidth-1:0] mulStatus;
  logic start;
  logic mulDone;
  logic accept;

  assign accept = (hsState == hsIdle) && req && !ack;

  always_ff @(posedge clock) begin
    if (accept) begin
      opA <= operandA;
      opB <= operandB;
    end
  end

  fpuMul16 #(
    .width(fpuPkg::fp16SigWidth)
  ) mulUnit (
    .clock(clock),
    .reset(reset),
    .start(start),
    .in1(opA),
    .in2(opB),
    .result(mulResult),
    .status(mulStatus),
    .done(mulDone)
  );

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      hsState <= hsWaitReq;
      start <= 1'b0;
      ack <= 1'b0;
      result <= '0;
      zero <= 1'b0;
      negative <= 1'b0;
      status <= '0;
    end else begin
      start <= 1'b0;
      case (hsState)
        // A req still high from before reset is not a new request.
        hsWaitReq: if (!req) hsState <= hsIdle;
        hsIdle: begin
          if (accept) begin
            start <= 1'b1;
            hsState <= hsBusy;
          end
        end
        hsBusy: begin
          if (mulDone) begin
            result <= mulResult;
            zero <= (mulResult[signPos-1:0] == '0);
            negative <= mulResult[signPos];
            status <= mulStatus;
            ack <= 1'b1;
            hsState <= hsAck;
          end
        end
        hsAck: begin
          // Outputs hold until the host drops req.
          if (!req) begin
            ack <= 1'b0;
            hsState <= hsIdle;
          end
        end
        default: hsState <= hsWaitReq;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- fpuCoprocessor_props.sv
/*
  Handshake checks for the multiply coprocessor.
  Bound into fpuCoprocessor; ack follows req in both directions and
  the returned result and flags hold still while ack is high.
*/

`timescale 1ns/100ps
`default_nettype none

module fpuCoprocessorProps (
  input logic                                 clock,
  input logic                                 reset,
  input logic                                 req,
  input logic                                 ack,
  input logic [fpuPkg::fp16Width-1:0]         result,
  input logic                                 zero,
  input logic                                 negative,
  input logic [fpuPkg::statusWidth-1:0]       status
);

  // Ack only answers a pending request.
  ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> req)
    else $error("ack rose while req was low");

  // Ack is released only once the host has dropped req.
  ackFallsAfterReq: assert property (@(posedge clock) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  // Returned values are frozen during the acknowledge phase.
  outputsStable: assert property (@(posedge clock) disable iff (reset)
    (ack && $past(ack)) |-> ($stable(result) && $stable(status)
                             && $stable(zero) && $stable(negative)))
    else $error("outputs changed while ack was high");

endmodule

bind fpuCoprocessor fpuCoprocessorProps handshakeProps (
  .clock(clock),
  .reset(reset),
  .req(req),
  .ack(ack),
  .result(result),
  .zero(zero),
  .negative(negative),
  .status(status)
);

`default_nettype wire

//--- fpuMul16.sv
/*
  Binary16 multiply unit.
  Sign and exponent datapath around a sequential significand multiplier
  and a rounding normalizer. A start pulse runs one multiply; done
  pulses once with result and status valid.
*/

`timescale 1ns/100ps
`default_nettype none

module fpuMul16 #(
  parameter int width = 11
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             start,
  input  logic [fpuPkg::fp16Width-1:0]     in1,
  input  logic [fpuPkg::fp16Width-1:0]     in2,
  output logic [fpuPkg::fp16Width-1:0]     result,
  output logic [fpuPkg::statusWidth-1:0]   status,
  output logic                             done
);

  localparam int expWidth = fpuPkg::fp16ExpWidth;
  localparam int fracWidth = fpuPkg::fp16FracWidth;
  localparam int signPos = fpuPkg::fp16Width - 1;
  localparam int expSumWidth = expWidth + 2;

  typedef enum logic [1:0] {
    stateIdle,
    stateComputing,
    stateFinishing
  } mulStateType;

  mulStateType state;

  logic [expWidth-1:0] exp1;
  logic [expWidth-1:0] exp2;
  logic [expWidth-1:0] effExp1;
  logic [expWidth-1:0] effExp2;
  logic [width-1:0] sig1;
  logic [width-1:0] sig2;
  logic [2*width-1:0] sigProduct;
  logic signed [expSumWidth-1:0] unnormExp;
  logic outSign;
  logic mulDone;
  logic [fpuPkg::fp16Width-1:0] normOut;
  logic [fpuPkg::statusWidth-1:0] normStatus;

  assign outSign = in1[signPos] ^ in2[signPos];
  assign exp1 = in1[signPos-1 -: expWidth];
  assign exp2 = in2[signPos-1 -: expWidth];

  // Implicit bit is clear for zero and subnormal operands.
  assign sig1 = {exp1 != '0, in1[fracWidth-1:0]};
  assign sig2 = {exp2 != '0, in2[fracWidth-1:0]};

  // Subnormals carry the exponent of the smallest normal.
  assign effExp1 = (exp1 == '0) ? expWidth'(1) : exp1;
  assign effExp2 = (exp2 == '0) ? expWidth'(1) : exp2;
  assign unnormExp = expSumWidth'(effExp1) + expSumWidth'(effExp2)
                   - expSumWidth'(fpuPkg::fp16Bias);

  fpuMultiplier #(
    .width(width)
  ) sigMultiplier (
    .clock(clock),
    .reset(reset),
    .start(start),
    .multiplicand(sig1),
    .multiplier(sig2),
    .product(sigProduct),
    .done(mulDone)
  );

  fpuNormalizer mulNormalizer (
    .sign(outSign),
    .unnormExp(unnormExp),
    .unnormProduct(sigProduct),
    .normOut(normOut),
    .status(normStatus)
  );

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= stateIdle;
    end else begin
      case (state)
        stateIdle: if (start) state <= stateComputing;
        stateComputing: if (mulDone) state <= stateFinishing;
        stateFinishing: state <= stateIdle;
        default: state <= stateIdle;
      endcase
    end
  end

  // Capture the rounded result as the multiplier finishes.
  always_ff @(posedge clock) begin
    if (state == stateComputing && mulDone) begin
      result <= normOut;
      status <= normStatus;
    end
  end

  assign done = (state == stateFinishing);

endmodule

`default_nettype wire

//--- fpuMultiplier.sv
/*
  Sequential shift-add multiplier.
  Unsigned product of two width-bit values, one partial product per
  cycle. Done pulses for one cycle after the last step; the product
  then holds until the next start.
*/

`timescale 1ns/100ps
`default_nettype none

module fpuMultiplier #(
  parameter int width = 11
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  logic [width-1:0]     multiplicand,
  input  logic [width-1:0]     multiplier,
  output logic [2*width-1:0]   product,
  output logic                 done
);

  localparam int countWidth = $clog2(width + 1);

  logic [2*width-1:0] accumulator;
  logic [2*width-1:0] mcandShift;
  logic [width-1:0]   mplierShift;
  logic [countWidth-1:0] bitCount;

  // Accumulate shifted multiplicand for each set multiplier bit.
  always_ff @(posedge clock) begin
    if (start) begin
      accumulator <= '0;
      mcandShift <= {{width{1'b0}}, multiplicand};
      mplierShift <= multiplier;
    end else if (bitCount != '0) begin
      if (mplierShift[0]) begin
        accumulator <= accumulator + mcandShift;
      end
      mcandShift <= mcandShift << 1;
      mplierShift <= mplierShift >> 1;
    end
  end

  // Step counter; done follows the final step.
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      bitCount <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        bitCount <= countWidth'(width);
      end else if (bitCount != '0) begin
        bitCount <= bitCount - 1'b1;
        if (bitCount == countWidth'(1)) begin
          done <= 1'b1;
        end
      end
    end
  end

  assign product = accumulator;

endmodule

`default_nettype wire

//--- fpuNormalizer.sv
/*
  Binary16 product normalizer.
  Takes the raw significand product and the unbiased-sum exponent,
  normalizes, denormalizes tiny results, rounds to nearest-even and
  raises overflow, underflow and inexact.
*/

`timescale 1ns/100ps
`default_nettype none

module fpuNormalizer (
  input  logic                                   sign,
  input  logic signed [fpuPkg::fp16ExpWidth+1:0] unnormExp,
  input  logic [2*fpuPkg::fp16SigWidth-1:0]      unnormProduct,
  output logic [fpuPkg::fp16Width-1:0]           normOut,
  output logic [fpuPkg::statusWidth-1:0]         status
);

  localparam int sigWidth = fpuPkg::fp16SigWidth;
  localparam int fracWidth = fpuPkg::fp16FracWidth;
  localparam int expWidth = fpuPkg::fp16ExpWidth;
  localparam int prodWidth = 2 * sigWidth;
  // Product bit just below the kept significand.
  localparam int guardPos = prodWidth - 2 - sigWidth;

  logic [prodWidth-1:0] sig;
  logic [prodWidth-1:0] lostMask;
  logic [sigWidth:0]    sigRounded;
  logic [expWidth-1:0]  expField;
  logic sticky;
  logic found;
  logic tiny;
  logic guardBit;
  logic roundBit;
  logic restBits;
  logic roundUp;
  logic inexact;
  logic overflow;
  int expWork;
  int lzc;
  int leftShift;
  int rightShift;

  always_comb begin
    sig = unnormProduct;
    expWork = int'(unnormExp);
    sticky = 1'b0;
    found = 1'b0;
    lzc = 0;
    leftShift = 0;
    rightShift = 0;
    lostMask = '0;

    if (sig[prodWidth-1]) begin
      // Significand in [2,4), one step right.
      sticky = sig[0];
      sig = sig >> 1;
      expWork = expWork + 1;
    end else begin
      for (int i = prodWidth - 2; i >= 0; i--) begin
        if (!found) begin
          if (sig[i]) begin
            found = 1'b1;
          end else begin
            lzc = lzc + 1;
          end
        end
      end
      // Left shift stops once the exponent reaches one.
      if (expWork > 1) begin
        leftShift = (lzc < expWork - 1) ? lzc : expWork - 1;
      end
      sig = sig << leftShift;
      expWork = expWork - leftShift;
    end

    // Below the normal range, shift right into the subnormal format.
    if (expWork < 1) begin
      rightShift = 1 - expWork;
      lostMask = ~({prodWidth{1'b1}} << rightShift);
      sticky = sticky | (|(sig & lostMask));
      sig = sig >> rightShift;
      expWork = 1;
    end
    tiny = ~sig[prodWidth-2];

    guardBit = sig[guardPos];
    roundBit = sig[guardPos-1];
    restBits = sticky | (|sig[guardPos-2:0]);
    inexact = guardBit | roundBit | restBits;
    // Ties go to the even significand.
    roundUp = guardBit & (roundBit | restBits | sig[guardPos+1]);

    sigRounded = {1'b0, sig[prodWidth-2 -: sigWidth]} + {{sigWidth{1'b0}}, roundUp};
    if (sigRounded[sigWidth]) begin
      sigRounded = sigRounded >> 1;
      expWork = expWork + 1;
    end
    overflow = expWork > fpuPkg::fp16ExpMax;
    // No implicit bit after rounding means the result stays subnormal.
    expField = sigRounded[sigWidth-1] ? expWork[expWidth-1:0] : '0;

    normOut = {sign, expField, sigRounded[fracWidth-1:0]};
    status = '0;
    if (unnormProduct == '0) begin
      normOut = {sign, {(fpuPkg::fp16Width - 1){1'b0}}};
    end else if (overflow) begin
      normOut = {sign, {expWidth{1'b1}}, {fracWidth{1'b0}}};
      status[fpuPkg::flagOverflow] = 1'b1;
      status[fpuPkg::flagInexact] = 1'b1;
    end else begin
      status[fpuPkg::flagInexact] = inexact;
      status[fpuPkg::flagUnderflow] = tiny & inexact;
    end
  end

endmodule

`default_nettype wire

//--- fpuPkg.sv
/*
  Half-precision FPU definitions.
  Field widths, exponent bias and range for IEEE binary16, and the
  bit positions of the status-flag vector shared by the multiply unit.
*/

`default_nettype none

package fpuPkg;

  // Whole binary16 word, laid out as sign, exponent, fraction.
  localparam int fp16Width = 16;

  // Exponent field width.
  localparam int fp16ExpWidth = 5;

  // Stored fraction width.
  localparam int fp16FracWidth = 10;

  // Significand with the implicit bit in front.
  localparam int fp16SigWidth = fp16FracWidth + 1;

  // Exponent bias.
  localparam int fp16Bias = 15;

  // Largest biased exponent of a finite number.
  localparam int fp16ExpMax = 30;

  // Status-flag vector layout.
  localparam int statusWidth = 3;
  localparam int flagOverflow = 0;
  localparam int flagUnderflow = 1;
  localparam int flagInexact = 2;

endpackage

`default_nettype wire

//--- tbFpuCoprocessor.sv
/*
  Testbench for the binary16 multiply coprocessor.
  Runs 300 req/ack transactions with LFSR operands and forced corner
  cases, and compares every result against a reference multiply.
*/

`timescale 1ns/100ps
`default_nettype none

module tbFpuCoprocessor;

  localparam int ackTimeout = 100;
  localparam int txnCount = 300;

  logic clock;
  logic reset;
  logic req;
  logic [15:0] operandA;
  logic [15:0] operandB;
  logic ack;
  logic [15:0] result;
  logic zero;
  logic negative;
  logic [fpuPkg::statusWidth-1:0] status;

  logic [31:0] lfsrState;
  logic [15:0] a;
  logic [15:0] b;
  logic [18:0] expected;
  logic [31:0] holdBits;
  int txn;

  fpuCoprocessor UUT (
    .clock(clock),
    .reset(reset),
    .req(req),
    .operandA(operandA),
    .operandB(operandB),
    .ack(ack),
    .result(result),
    .zero(zero),
    .negative(negative),
    .status(status)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[30:0], lfsrState[31]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // Expected {status, result}, from exact integer significand math.
  function automatic logic [18:0] fpMulRef(input logic [15:0] x, input logic [15:0] y);
    logic sign;
    logic inexact;
    logic tiny;
    logic [2:0] flags;
    logic [15:0] res;
    int expX;
    int expY;
    int msb;
    int biased;
    int effExp;
    int shift;
    longint sigX;
    longint sigY;
    longint prod;
    longint q;
    longint rem;
    longint half;
    sign = x[15] ^ y[15];
    expX = x[14:10];
    expY = y[14:10];
    sigX = (expX != 0) ? 1024 + x[9:0] : x[9:0];
    sigY = (expY != 0) ? 1024 + y[9:0] : y[9:0];
    if (expX == 0) expX = 1;
    if (expY == 0) expY = 1;
    prod = sigX * sigY;
    if (prod == 0) begin
      return {3'b000, sign, 15'h0000};
    end
    msb = 0;
    for (int i = 0; i < 22; i++) begin
      if (prod[i]) msb = i;
    end
    // Value is prod * 2^(expX+expY-50); biased exponent of its leading one.
    biased = msb + expX + expY - 35;
    tiny = (biased < 1);
    effExp = tiny ? 1 : biased;
    // One result ulp is 2^(effExp-25).
    shift = effExp + 25 - expX - expY;
    rem = 0;
    if (shift <= 0) begin
      q = prod << (-shift);
    end else begin
      if (shift > 40) shift = 40;
      q = prod >> shift;
      rem = prod - (q << shift);
      half = longint'(1) << (shift - 1);
      if (rem > half || (rem == half && q[0])) q = q + 1;
    end
    inexact = (rem != 0);
    if (q >= 2048) begin
      q = q >> 1;
      effExp = effExp + 1;
    end
    flags = '0;
    if (effExp > fpuPkg::fp16ExpMax) begin
      res = {sign, 5'h1f, 10'h000};
      flags[fpuPkg::flagOverflow] = 1'b1;
      flags[fpuPkg::flagInexact] = 1'b1;
    end else begin
      res = (q >= 1024) ? {sign, effExp[4:0], q[9:0]} : {sign, 5'h00, q[9:0]};
      flags[fpuPkg::flagInexact] = inexact;
      flags[fpuPkg::flagUnderflow] = tiny & inexact;
    end
    return {flags, res};
  endfunction

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic checkField(input string name, input logic [15:0] got,
                            input logic [15:0] want);
    assert (got === want) else begin
      reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  // Result and all flags against the reference {status, result}.
  task automatic checkOutputs(input logic [18:0] want);
    checkField("result", result, want[15:0]);
    checkField("status", 16'(status), 16'(want[18:16]));
    checkField("zero", 16'(zero), 16'(want[14:0] == 15'h0000));
    checkField("negative", 16'(negative), 16'(want[15]));
  endtask

  task automatic waitForAck(input logic level);
    int cycles;
    cycles = 0;
    while (ack !== level) begin
      @(posedge clock);
      cycles++;
      if (cycles > ackTimeout) begin
        reportFailure($sformatf("Timed out waiting for ack to go to %0b.", level));
      end
    end
  endtask

  task automatic randomOperand(output logic [15:0] op);
    logic [31:0] bits;
    takeBits(16, bits);
    op = bits[15:0];
    // Infinity and NaN encodings are never driven.
    if (op[14:10] == 5'h1f) op[14:10] = 5'd30;
  endtask

  task automatic makeOperands(input int index, output logic [15:0] x, output logic [15:0] y);
    randomOperand(x);
    randomOperand(y);
    case (index % 10)
      0: x[14:0] = 15'h0000;
      1: begin
        x[14:10] = 5'd1 + x[12:10];
        y[14:10] = 5'd2 + y[12:10];
      end
      2: x[14:10] = 5'd0;
      3: begin
        x[14:10] = 5'd23 + x[12:10];
        y[14:10] = 5'd23 + y[12:10];
      end
      // 1.5 times (1 + 2^-10) is a tie that rounds up to even.
      4: begin
        x = {x[15], 15'h3e00};
        y = {y[15], 15'h3c01};
      end
      // 1.5 times (1 + 3*2^-10) is a tie that stays even.
      5: begin
        x = {x[15], 15'h3e00};
        y = {y[15], 15'h3c03};
      end
      6: begin
        x[14:10] = 5'd0;
        y[14:10] = 5'd0;
      end
      default: ;
    endcase
  endtask

  initial begin
    reset = 1'b1;
    req = 1'b0;
    operandA = '0;
    operandB = '0;
    lfsrState = 32'h4124;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    for (txn = 0; txn < txnCount; txn++) begin
      makeOperands(txn, a, b);
      expected = fpMulRef(a, b);
      req <= 1'b1;
      operandA <= a;
      operandB <= b;
      waitForAck(1'b1);
      checkOutputs(expected);

      // Hold req a while longer; ack and outputs must not move.
      takeBits(3, holdBits);
      repeat (holdBits[2:0]) begin
        @(posedge clock);
        checkField("ack", 16'(ack), 16'h0001);
        checkOutputs(expected);
      end
      req <= 1'b0;
      waitForAck(1'b0);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
